// ==== common/hex_dump_pkg.sv ====
`default_nettype none

package hex_dump_pkg;

  // Sample and text widths
  localparam int VALUE_BITS = 32;
  localparam int TAG_BITS   = 4;
  localparam int HEX_CHARS  = VALUE_BITS / 4;
  localparam int HEX_IDX_BITS = $clog2(HEX_CHARS);

  // Tag, colon, hex digits, CR, LF
  localparam int LINE_CHARS    = HEX_CHARS + 4;
  localparam int LINE_IDX_BITS = $clog2(LINE_CHARS);

  // Less than two lines deep
  localparam int FIFO_DEPTH    = 16;
  localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

  // Short bit period keeps simulation fast
  localparam int CLKS_PER_BIT  = 8;
  localparam int BAUD_CNT_BITS = $clog2(CLKS_PER_BIT);

  typedef logic [7:0] ascii_t;

  localparam ascii_t ASCII_COLON = 8'h3a;
  localparam ascii_t ASCII_CR    = 8'h0d;
  localparam ascii_t ASCII_LF    = 8'h0a;

  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [VALUE_BITS-1:0] value;
  } sample_t;

  // Index 0 is the least significant nibble
  typedef ascii_t [HEX_CHARS-1:0] hex_text_t;

  typedef enum logic [1:0] {FMT_IDLE, FMT_CONVERT, FMT_EMIT} fmt_state_e;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  // Upper case digits for 10 to 15
  function automatic ascii_t nibble_to_ascii(input logic [3:0] nibble);
    if (nibble < 4'd10) begin
      return "0" + ascii_t'(nibble);
    end
    return "A" + ascii_t'(nibble - 4'd10);
  endfunction

endpackage

`default_nettype wire

// ==== hex_dump_uart.f ====
common/hex_dump_pkg.sv
src/hex_ascii.sv
line_formatter/hex_line_formatter.sv
src/char_fifo.sv
uart/uart_tx.sv
src/hex_dump_uart.sv
tests/hex_dump_uart_tb.sv

// ==== line_formatter/hex_line_formatter.sv ====
`default_nettype none

module hex_line_formatter (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         sample_strobe,
  input  wire hex_dump_pkg::sample_t  sample,
  input  wire                         full,
  output logic                        push,
  output hex_dump_pkg::ascii_t        push_char,
  output logic                        busy,
  output logic                        sample_dropped
);
  import hex_dump_pkg::*;

  fmt_state_e               state;
  logic [LINE_IDX_BITS-1:0] char_idx;
  logic [TAG_BITS-1:0]      tag_q;
  logic                     convert_strobe;
  logic [VALUE_BITS-1:0]    convert_value;
  hex_text_t                hex_text;
  logic [HEX_IDX_BITS-1:0]  digit_sel;

  // Only an idle formatter takes a new sample
  assign convert_strobe = sample_strobe && (state == FMT_IDLE);
  assign busy           = (state != FMT_IDLE);
  assign push           = (state == FMT_EMIT) && !full;

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= FMT_IDLE;
      char_idx       <= '0;
      sample_dropped <= 1'b0;
    end else begin
      // Overrun samples only raise the drop pulse
      sample_dropped <= sample_strobe && (state != FMT_IDLE);
      case (state)
        FMT_IDLE: begin
          if (convert_strobe) begin
            state <= FMT_CONVERT;
          end
        end
        // hex_text is ready after this cycle
        FMT_CONVERT: begin
          state    <= FMT_EMIT;
          char_idx <= '0;
        end
        FMT_EMIT: begin
          if (push) begin
            if (char_idx == LINE_IDX_BITS'(LINE_CHARS - 1)) begin
              state    <= FMT_IDLE;
              char_idx <= '0;
            end else begin
              char_idx <= char_idx + 1'b1;
            end
          end
        end
        default: state <= FMT_IDLE;
      endcase
    end
  end

  // Accepted sample, held for the whole line
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_q         <= '0;
      convert_value <= '0;
    end else if (convert_strobe) begin
      tag_q         <= sample.tag;
      convert_value <= sample.value;
    end
  end

  hex_ascii i_hex_ascii (
    .clk      (clk),
    .reset    (reset),
    .value    (convert_value),
    .hex_text (hex_text)
  );

  // Index 2 maps to the most significant digit
  assign digit_sel = HEX_IDX_BITS'(HEX_CHARS + 1 - int'(char_idx));

  always_comb begin
    case (char_idx)
      LINE_IDX_BITS'(0):              push_char = nibble_to_ascii(tag_q);
      LINE_IDX_BITS'(1):              push_char = ASCII_COLON;
      LINE_IDX_BITS'(LINE_CHARS - 2): push_char = ASCII_CR;
      LINE_IDX_BITS'(LINE_CHARS - 1): push_char = ASCII_LF;
      default:                        push_char = hex_text[digit_sel];
    endcase
  end

  a_idx_range: assert property (
    @(posedge clk) disable iff (reset) char_idx <= LINE_IDX_BITS'(LINE_CHARS - 1)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f hex_dump_uart.f \
  --top-module hex_dump_uart_tb -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vhex_dump_uart_tb > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Something failed" sim.log \
  && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// ==== src/char_fifo.sv ====
`default_nettype none

module char_fifo (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        push,
  input  wire hex_dump_pkg::ascii_t  push_char,
  input  wire                        pop,
  output hex_dump_pkg::ascii_t       pop_char,
  output logic                       full,
  output logic                       empty
);
  import hex_dump_pkg::*;

  ascii_t                   mem [FIFO_DEPTH];
  logic [FIFO_PTR_BITS-1:0] wr_ptr;
  logic [FIFO_PTR_BITS-1:0] rd_ptr;
  logic [FIFO_CNT_BITS-1:0] count;

  assign full     = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
  assign empty    = (count == '0);
  // Head entry visible without a read cycle
  assign pop_char = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_char;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) full |-> !push
  );

  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset) empty |-> !pop
  );

endmodule

`default_nettype wire

// ==== src/hex_ascii.sv ====
`default_nettype none

module hex_ascii (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire [hex_dump_pkg::VALUE_BITS-1:0]    value,
  output hex_dump_pkg::hex_text_t               hex_text
);
  import hex_dump_pkg::*;

  // One character per nibble, registered
  always_ff @(posedge clk) begin
    if (reset) begin
      hex_text <= '0;
    end else begin
      for (int i = 0; i < HEX_CHARS; i++) begin
        hex_text[i] <= nibble_to_ascii(value[i*4 +: 4]);
      end
    end
  end

  // Every byte is either cleared or a legal hex digit
  for (genvar g = 0; g < HEX_CHARS; g++) begin : g_char_check
    a_hex_char: assert property (
      @(posedge clk) disable iff (reset)
      (hex_text[g] == 8'h00) ||
      (hex_text[g] inside {["0":"9"], ["A":"F"]})
    );
  end

endmodule

`default_nettype wire

// ==== src/hex_dump_uart.sv ====
`default_nettype none

module hex_dump_uart (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         sample_strobe,
  input  wire hex_dump_pkg::sample_t  sample,
  output logic                        tx,
  output logic                        busy,
  output logic                        sample_dropped
);
  import hex_dump_pkg::*;

  // Formatter to buffer
  logic   push;
  ascii_t push_char;
  logic   full;

  // Buffer to transmitter
  logic   pop;
  ascii_t pop_char;
  logic   empty;

  hex_line_formatter i_hex_line_formatter (
    .clk            (clk),
    .reset          (reset),
    .sample_strobe  (sample_strobe),
    .sample         (sample),
    .full           (full),
    .push           (push),
    .push_char      (push_char),
    .busy           (busy),
    .sample_dropped (sample_dropped)
  );

  char_fifo i_char_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_char (push_char),
    .pop       (pop),
    .pop_char  (pop_char),
    .full      (full),
    .empty     (empty)
  );

  uart_tx i_uart_tx (
    .clk      (clk),
    .reset    (reset),
    .empty    (empty),
    .pop_char (pop_char),
    .pop      (pop),
    .tx       (tx)
  );

endmodule

`default_nettype wire

// ==== tests/hex_dump_uart_tb.sv ====
`default_nettype none

module hex_dump_uart_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import hex_dump_pkg::*;

  localparam int NUM_ROWS       = 10;
  localparam int FRAME_CLKS     = 10 * CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * LINE_CHARS * FRAME_CLKS + 2000;

  // First character of a line sits at the top index
  typedef ascii_t [LINE_CHARS-1:0] line_t;

  typedef struct packed {
    sample_t     smp;
    logic [7:0]  delay;
    logic        drop;
    line_t       line;
  } row_t;

  typedef struct packed {
    logic [7:0] row;
    line_t      line;
  } exp_t;

  logic    clk;
  logic    reset;
  logic    sample_strobe;
  sample_t sample;
  logic    tx;
  logic    busy;
  logic    sample_dropped;

  row_t tbl [NUM_ROWS];
  exp_t exp_q [$];
  logic row_bad [NUM_ROWS];
  logic reset_bad;
  int   errors;
  int   lines_seen;
  int   lines_expected;

  hex_dump_uart i_hex_dump_uart (
    .clk            (clk),
    .reset          (reset),
    .sample_strobe  (sample_strobe),
    .sample         (sample),
    .tx             (tx),
    .busy           (busy),
    .sample_dropped (sample_dropped)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Expected text: tag, colon, digits from the top nibble down, CR, LF
  function automatic line_t make_line(input sample_t s);
    line_t l;
    l[LINE_CHARS-1] = nibble_to_ascii(s.tag);
    l[LINE_CHARS-2] = ":";
    for (int i = 0; i < HEX_CHARS; i++) begin
      l[2+i] = nibble_to_ascii(s.value[i*4 +: 4]);
    end
    l[1] = 8'h0d;
    l[0] = 8'h0a;
    return l;
  endfunction

  // Row -1 stands for the reset test
  task automatic mark_fail(input int row);
    errors++;
    if (row < 0) begin
      reset_bad = 1'b1;
    end else begin
      row_bad[row] = 1'b1;
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp, input int row);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      mark_fail(row);
    end
  endtask

  task automatic check_char(input ascii_t got, input ascii_t exp, input int row, input int pos);
    if (got !== exp) begin
      $display("[ERROR] %0t: test %0d char %0d is 0x%02h, expected 0x%02h",
               $time, row, pos, got, exp);
      mark_fail(row);
    end
  endtask

  task automatic check_drop(input logic got, input logic exp, input int row);
    if (got !== exp) begin
      $display("[ERROR] %0t: test %0d sample_dropped is %b, expected %b",
               $time, row, got, exp);
      mark_fail(row);
    end
  endtask

  // Compares each character, then reports the finished test
  task automatic check_line(input line_t got, input line_t exp, input int row);
    for (int i = LINE_CHARS - 1; i >= 0; i--) begin
      check_char(got[i], exp[i], row, LINE_CHARS - 1 - i);
    end
    $display("test %0d: line %s %s", row, got[LINE_CHARS-1:2], row_bad[row] ? "FAIL" : "pass");
  endtask

  task automatic build_table();
    tbl[0] = '{smp: '{tag: 4'h3, value: 32'h0123abcd}, delay: 8'd5, drop: 1'b0,
               line: {"3:0123ABCD", 8'h0d, 8'h0a}};
    tbl[1] = '{smp: '{tag: 4'h9, value: 32'h89abcdef}, delay: 8'd0, drop: 1'b0,
               line: {"9:89ABCDEF", 8'h0d, 8'h0a}};
    tbl[2] = '{smp: '{tag: 4'hf, value: 32'hffffffff}, delay: 8'd0, drop: 1'b0,
               line: {"F:FFFFFFFF", 8'h0d, 8'h0a}};
    // Strobed while the previous line is still being written
    tbl[3] = '{smp: '{tag: 4'h1, value: 32'hdeadbeef}, delay: 8'd2, drop: 1'b1,
               line: {"1:DEADBEEF", 8'h0d, 8'h0a}};
    tbl[4] = '{smp: '{tag: 4'h0, value: 32'h00000000}, delay: 8'd0, drop: 1'b0,
               line: {"0:00000000", 8'h0d, 8'h0a}};
    for (int r = 5; r < NUM_ROWS; r++) begin
      tbl[r].smp.tag   = 4'($urandom);
      tbl[r].smp.value = $urandom;
      tbl[r].delay     = 8'($urandom % 21);
      tbl[r].drop      = 1'b0;
      tbl[r].line      = make_line(tbl[r].smp);
    end
    lines_expected = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_bad[r] = 1'b0;
      if (!tbl[r].drop) begin
        lines_expected++;
      end
    end
  endtask

  task automatic check_reset_state();
    logic stayed_high;
    @(negedge clk);
    check_level("tx after reset", tx, 1'b1, -1);
    check_level("busy after reset", busy, 1'b0, -1);
    check_drop(sample_dropped, 1'b0, -1);
    stayed_high = 1'b1;
    // No start bit without a sample
    repeat (20) begin
      @(negedge clk);
      stayed_high &= tx;
    end
    check_level("tx idle before first sample", stayed_high, 1'b1, -1);
    $display("test reset: %s", reset_bad ? "FAIL" : "pass");
  endtask

  task automatic apply_row(input int r);
    logic dropped;
    // Accepted rows go in as soon as busy falls
    if (!tbl[r].drop) begin
      while (busy) @(negedge clk);
    end
    repeat (tbl[r].delay) @(negedge clk);
    @(posedge clk);
    sample_strobe <= 1'b1;
    sample        <= tbl[r].smp;
    if (!tbl[r].drop) begin
      exp_q.push_back(exp_t'{row: 8'(r), line: tbl[r].line});
    end
    @(posedge clk);
    sample_strobe <= 1'b0;
    @(negedge clk);
    dropped = sample_dropped;
    check_drop(dropped, tbl[r].drop, r);
    // Busy rises right after acceptance, or was already high for an overrun
    check_level("busy after strobe", busy, 1'b1, r);
    // Drop pulse lasts a single cycle
    @(negedge clk);
    check_drop(sample_dropped, 1'b0, r);
    if (tbl[r].drop) begin
      $display("test %0d: drop %s", r, row_bad[r] ? "FAIL" : "pass");
    end
  endtask

  // UART line decoder, sampling mid-bit on falling clock edges
  initial begin : line_decoder
    ascii_t ch;
    line_t  got;
    exp_t   e;
    int     n;
    int     cur_row;
    n = 0;
    got = '0;
    while (reset !== 1'b0) @(negedge clk);
    forever begin
      do @(negedge clk); while (tx !== 1'b0);
      repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
      for (int b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        ch[b] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      cur_row = (exp_q.size() > 0) ? int'(exp_q[0].row) : -1;
      check_level("stop bit", tx, 1'b1, cur_row);
      got = {got[LINE_CHARS-2:0], ch};
      n++;
      if (n == LINE_CHARS) begin
        n = 0;
        lines_seen++;
        if (exp_q.size() == 0) begin
          $display("A line arrived on tx with no accepted sample left to match it");
          errors++;
          reset_bad = 1'b1;
        end else begin
          e = exp_q.pop_front();
          check_line(got, e.line, int'(e.row));
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d of %0d lines decoded",
             cycles, lines_seen, lines_expected);
    $display("Something failed");
    $finish;
  end

  initial begin
    int failed;
    void'($urandom(32'hc2401b37));
    reset          = 1'b1;
    sample_strobe  = 1'b0;
    sample         = '0;
    errors         = 0;
    lines_seen     = 0;
    reset_bad      = 1'b0;
    build_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    check_reset_state();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end
    while (lines_seen < lines_expected) @(negedge clk);
    // Room for one more line in case a dropped sample shows up
    repeat (LINE_CHARS * FRAME_CLKS) @(negedge clk);
    failed = reset_bad ? 1 : 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      failed += row_bad[r] ? 1 : 0;
    end
    $display("%0d tests, %0d failed, %0d errors, %0d lines decoded",
             NUM_ROWS + 1, failed, errors, lines_seen);
    if (errors == 0 && lines_seen == lines_expected) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        empty,
  input  wire hex_dump_pkg::ascii_t  pop_char,
  output logic                       pop,
  output logic                       tx
);
  import hex_dump_pkg::*;

  tx_state_e                          state;
  logic [BAUD_CNT_BITS-1:0]           baud_cnt;
  logic [$clog2($bits(ascii_t))-1:0]  bit_idx;
  ascii_t                             shift_q;
  logic                               bit_end;

  // Grab the head character as soon as the line is free
  assign pop     = (state == TX_IDLE) && !empty;
  assign bit_end = (baud_cnt == BAUD_CNT_BITS'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end else begin
      baud_cnt <= (state == TX_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          if (pop) begin
            state <= TX_START;
            tx    <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx      <= shift_q[0];
          end
        end
        // LSB first
        TX_DATA: begin
          if (bit_end) begin
            if (bit_idx == $bits(bit_idx)'($bits(ascii_t) - 1)) begin
              state <= TX_STOP;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift_q[0];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Remaining data bits, next one at bit 0
  always_ff @(posedge clk) begin
    if (pop) begin
      shift_q <= pop_char;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

  a_idle_high: assert property (
    @(posedge clk) disable iff (reset) (state == TX_IDLE) |-> tx
  );

endmodule

`default_nettype wire
